// ==== sat_cfg.svh ====
`ifndef SAT_CFG_SVH
`define SAT_CFG_SVH

// Variable index width and count
`define MAX_VARS_BITS 3
`define MAX_VARS 8

// Clause memory size
`define MAX_CLAUSES_BITS 5
`define MAX_CLAUSES 32

`define LITS_PER_CLAUSE 3   // 3-CNF only

`endif

// ==== logic/sat_types_pkg.sv ====
`include "sat_cfg.svh"

package sat_types_pkg;

    typedef logic [`MAX_VARS_BITS-1:0]    var_idx_t;
    typedef logic [`MAX_CLAUSES_BITS-1:0] clause_idx_t;
    typedef logic [`MAX_CLAUSES_BITS:0]   clause_cnt_t;  // Holds 0 up to MAX_CLAUSES
    typedef logic [`MAX_VARS-1:0]         assign_vec_t;

    // True when the variable value differs from negate
    typedef struct packed {
        var_idx_t var_idx;
        logic     negate;
    } literal_t;

    typedef struct packed {
        literal_t [`LITS_PER_CLAUSE-1:0] lit;
    } clause_t;

    // Variable with its value, for implications and decisions
    typedef struct packed {
        var_idx_t var_idx;
        logic     value;
    } config_var;

    typedef struct packed {
        config_var cv;
        logic      forced;  // 0 for a decision
    } trail_entry_t;

endpackage

// ==== logic/sat_ctrl_pkg.sv ====
package sat_ctrl_pkg;

    typedef enum logic [3:0] {
        IDLE,
        FIND_NEXT,
        DECIDE,
        BCP_INIT,
        BCP_CORE,
        BCP_WAIT,
        BACKPROP,
        SAT,
        UNSAT
    } control_state_t;

    // Stage tags of the propagation pipeline
    typedef enum logic [1:0] {
        READY,
        EVAL,
        PUSH
    } bcp_state_t;

endpackage

// ==== logic/sat_control.sv ====
`timescale 1ns/1ps
`include "sat_cfg.svh"

module sat_control
    import sat_types_pkg::*;
    import sat_ctrl_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    input  clause_cnt_t  num_clauses,
    input  logic         empty_imply,
    input  config_var    imply_head,
    input  logic         empty_trace,
    input  trail_entry_t trace_top,
    input  logic         bcp_busy,
    input  logic         conflict,
    input  logic         all_assigned,
    input  var_idx_t     dec_var,
    input  logic         vs_assigned_head,
    input  logic         vs_value_head,
    output logic         pop_imply,
    output logic         push_trace,
    output trail_entry_t trace_in,
    output logic         pop_trace,
    output logic         write_vs,
    output config_var    vs_in,
    output logic         unassign_in_vs,
    output logic         eval,
    output clause_idx_t  bcp_clause_idx,
    output logic         reset_bcp,
    output logic         sat,
    output logic         unsat
);

    control_state_t state;
    clause_idx_t    clause_idx;
    var_idx_t       sweep_cnt;
    logic           sweeping;
    trail_entry_t   pend_q;         // Assignment recorded in BCP_INIT
    logic           last_clause;

    assign last_clause = ({1'b0, clause_idx} + clause_cnt_t'(1)) >= num_clauses;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IDLE;
            sweeping   <= 1'b0;
            sweep_cnt  <= '0;
            clause_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (sweeping) begin
                        sweep_cnt <= sweep_cnt + 1'b1;
                        if (sweep_cnt == var_idx_t'(`MAX_VARS - 1)) begin
                            sweeping <= 1'b0;
                            state    <= FIND_NEXT;
                        end
                    end else if (start) begin
                        sweeping  <= 1'b1;
                        sweep_cnt <= '0;
                    end
                end
                FIND_NEXT: begin
                    if (empty_imply) begin
                        state <= DECIDE;
                    end else if (!vs_assigned_head) begin
                        pend_q <= '{cv: imply_head, forced: 1'b1};
                        state  <= BCP_INIT;
                    end else if (vs_value_head != imply_head.value) begin
                        state <= BACKPROP;  // Implied against current value
                    end
                end
                DECIDE: begin
                    if (all_assigned) begin
                        state <= SAT;
                    end else begin
                        pend_q <= '{cv: '{var_idx: dec_var, value: 1'b0}, forced: 1'b0};
                        state  <= BCP_INIT;
                    end
                end
                BCP_INIT: begin
                    clause_idx <= '0;
                    state      <= BCP_CORE;
                end
                BCP_CORE: begin
                    if (conflict) begin
                        state <= BACKPROP;
                    end else begin
                        clause_idx <= clause_idx + 1'b1;
                        if (last_clause)
                            state <= BCP_WAIT;
                    end
                end
                BCP_WAIT: begin
                    if (conflict)
                        state <= BACKPROP;
                    else if (!bcp_busy)
                        state <= FIND_NEXT;
                end
                BACKPROP: begin
                    // Forced entries are only popped, a decision gets flipped
                    if (empty_trace) begin
                        state <= UNSAT;
                    end else if (!trace_top.forced) begin
                        pend_q <= '{cv: '{var_idx: trace_top.cv.var_idx,
                                          value: ~trace_top.cv.value},
                                    forced: 1'b1};
                        state  <= BCP_INIT;
                    end
                end
                SAT, UNSAT: begin
                    if (start) begin
                        state     <= IDLE;
                        sweeping  <= 1'b1;
                        sweep_cnt <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        pop_imply      = 1'b0;
        push_trace     = 1'b0;
        pop_trace      = 1'b0;
        write_vs       = 1'b0;
        unassign_in_vs = 1'b0;
        reset_bcp      = 1'b0;
        eval           = 1'b0;
        vs_in          = pend_q.cv;
        case (state)
            IDLE: begin
                if (sweeping) begin
                    // Unassign one variable per cycle and drain the trail
                    write_vs       = 1'b1;
                    unassign_in_vs = 1'b1;
                    vs_in          = '{var_idx: sweep_cnt, value: 1'b0};
                    pop_trace      = 1'b1;
                    reset_bcp      = 1'b1;
                end
            end
            FIND_NEXT: pop_imply = !empty_imply;
            BCP_INIT: begin
                push_trace = 1'b1;
                write_vs   = 1'b1;
                reset_bcp  = 1'b1;  // Also flushes stale implications
            end
            BCP_CORE: eval = !conflict && (clause_cnt_t'(clause_idx) < num_clauses);
            BACKPROP: begin
                if (!empty_trace) begin
                    pop_trace      = 1'b1;
                    write_vs       = 1'b1;
                    unassign_in_vs = 1'b1;
                    vs_in          = trace_top.cv;
                end
            end
            default: ;
        endcase
    end

    assign trace_in       = pend_q;
    assign bcp_clause_idx = clause_idx;
    assign sat            = state == SAT;
    assign unsat          = state == UNSAT;

endmodule

// ==== logic/trail_stack.sv ====
`timescale 1ns/1ps
`include "sat_cfg.svh"

module trail_stack
    import sat_types_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         push_trace,
    input  logic         pop_trace,
    input  trail_entry_t trace_in,
    output trail_entry_t trace_top,
    output logic         empty_trace
);

    trail_entry_t             stack_mem [`MAX_VARS];
    logic [`MAX_VARS_BITS:0]  depth;
    var_idx_t                 top_idx;
    logic                     do_push;
    logic                     do_pop;

    assign do_push     = push_trace && (depth != `MAX_VARS);
    assign do_pop      = pop_trace && !empty_trace;
    assign empty_trace = depth == '0;
    assign top_idx     = var_idx_t'(depth - 1'b1);
    assign trace_top   = stack_mem[top_idx];

    always_ff @(posedge clock) begin
        if (reset)
            depth <= '0;
        else if (do_push)
            depth <= depth + 1'b1;
        else if (do_pop)
            depth <= depth - 1'b1;
    end

    always_ff @(posedge clock) begin
        if (do_push)
            stack_mem[var_idx_t'(depth)] <= trace_in;
    end

endmodule

// ==== logic/implication_queue.sv ====
`timescale 1ns/1ps
`include "sat_cfg.svh"

module implication_queue
    import sat_types_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      flush,
    input  logic      push_imply,
    input  config_var imply_in,
    input  logic      pop_imply,
    output config_var imply_head,
    output logic      empty_imply
);

    config_var               fifo_mem [`MAX_VARS];
    var_idx_t                rd_ptr;
    var_idx_t                wr_ptr;
    logic [`MAX_VARS_BITS:0] count;
    logic                    do_push;
    logic                    do_pop;

    assign do_push     = push_imply && (count != `MAX_VARS);  // Dropped when full
    assign do_pop      = pop_imply && !empty_imply;
    assign empty_imply = count == '0;
    assign imply_head  = fifo_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_push - do_pop;
        end
    end

    always_ff @(posedge clock) begin
        if (do_push)
            fifo_mem[wr_ptr] <= imply_in;
    end

endmodule

// ==== logic/var_state_table.sv ====
`timescale 1ns/1ps
`include "sat_cfg.svh"

module var_state_table
    import sat_types_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              write_vs,
    input  config_var                         vs_in,
    input  logic                              unassign_in_vs,
    input  var_idx_t [`LITS_PER_CLAUSE-1:0]   rd_var,
    output logic [`LITS_PER_CLAUSE-1:0]       rd_assigned,
    output logic [`LITS_PER_CLAUSE-1:0]       rd_value,
    output assign_vec_t                       assigned_vec,
    output assign_vec_t                       assignment
);

    always_ff @(posedge clock) begin
        if (reset) begin
            assigned_vec <= '0;
            assignment   <= '0;
        end else if (write_vs) begin
            assigned_vec[vs_in.var_idx] <= !unassign_in_vs;
            assignment[vs_in.var_idx]   <= !unassign_in_vs && vs_in.value;
        end
    end

    // One read port per literal of the clause under evaluation
    always_comb begin
        for (int i = 0; i < `LITS_PER_CLAUSE; i++) begin
            rd_assigned[i] = assigned_vec[rd_var[i]];
            rd_value[i]    = assignment[rd_var[i]];
        end
    end

endmodule

// ==== logic/bcp_core.sv ====
`timescale 1ns/1ps
`include "sat_cfg.svh"

module bcp_core
    import sat_types_pkg::*;
    import sat_ctrl_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              load_clause,
    input  clause_idx_t                       load_idx,
    input  clause_t                           load_data,
    input  logic                              eval,
    input  clause_idx_t                       bcp_clause_idx,
    input  logic                              reset_bcp,
    output var_idx_t [`LITS_PER_CLAUSE-1:0]   rd_var,
    input  logic [`LITS_PER_CLAUSE-1:0]       rd_assigned,
    input  logic [`LITS_PER_CLAUSE-1:0]       rd_value,
    output logic                              push_imply,
    output config_var                         imply_in,
    output logic                              conflict,
    output logic                              bcp_busy
);

    clause_t                       clause_mem [`MAX_CLAUSES];
    clause_t                       clause_q;        // Clause in the EVAL stage
    bcp_state_t                    eval_stage;
    bcp_state_t                    push_stage;
    config_var                     imply_q;
    assign_vec_t                   implied_mask;    // Variables already queued
    logic [`LITS_PER_CLAUSE-1:0]   lit_false;
    logic [`LITS_PER_CLAUSE-1:0]   lit_free;
    logic                          all_false;
    logic                          unit_found;
    config_var                     unit_lit;

    always_ff @(posedge clock) begin
        if (load_clause)
            clause_mem[load_idx] <= load_data;
        if (eval)
            clause_q <= clause_mem[bcp_clause_idx];
    end

    // Classify the registered clause against the current assignment
    always_comb begin
        unit_lit = '0;
        for (int i = 0; i < `LITS_PER_CLAUSE; i++) begin
            rd_var[i]    = clause_q.lit[i].var_idx;
            lit_free[i]  = !rd_assigned[i];
            lit_false[i] = rd_assigned[i] && (rd_value[i] == clause_q.lit[i].negate);
            if (lit_free[i]) begin
                unit_lit.var_idx = clause_q.lit[i].var_idx;
                unit_lit.value   = !clause_q.lit[i].negate;  // Value that makes it true
            end
        end
        all_false  = &lit_false;
        unit_found = ($countones(lit_free) == 1) && (&(lit_false | lit_free));
    end

    always_ff @(posedge clock) begin
        if (reset || reset_bcp) begin
            eval_stage   <= READY;
            push_stage   <= READY;
            conflict     <= 1'b0;
            implied_mask <= '0;
        end else begin
            eval_stage <= eval ? EVAL : READY;
            push_stage <= READY;
            if (eval_stage == EVAL) begin
                if (all_false) begin
                    conflict <= 1'b1;
                end else if (unit_found && !implied_mask[unit_lit.var_idx]) begin
                    push_stage                     <= PUSH;
                    imply_q                        <= unit_lit;
                    implied_mask[unit_lit.var_idx] <= 1'b1;
                end
            end
        end
    end

    assign push_imply = push_stage == PUSH;
    assign imply_in   = imply_q;
    assign bcp_busy   = (eval_stage == EVAL) || (push_stage == PUSH);

endmodule

// ==== logic/decider.sv ====
`timescale 1ns/1ps
`include "sat_cfg.svh"

module decider
    import sat_types_pkg::*;
(
    input  assign_vec_t assigned_vec,
    output logic        all_assigned,
    output var_idx_t    dec_var
);

    // Lowest unassigned index wins, scan runs from the top down
    always_comb begin
        dec_var = '0;
        for (int i = `MAX_VARS - 1; i >= 0; i--) begin
            if (!assigned_vec[i])
                dec_var = var_idx_t'(i);
        end
    end

    assign all_assigned = &assigned_vec;

endmodule

// ==== logic/sat_solver_top.sv ====
`timescale 1ns/1ps
`include "sat_cfg.svh"

module sat_solver_top
    import sat_types_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        load_clause,
    input  clause_idx_t load_idx,
    input  clause_t     load_data,
    input  clause_cnt_t num_clauses,
    input  logic        start,
    output logic        sat,
    output logic        unsat,
    output assign_vec_t assignment
);

    // Queue
    logic         pop_imply;
    logic         push_imply;
    logic         empty_imply;
    config_var    imply_in;
    config_var    imply_head;
    // Trail
    logic         push_trace;
    logic         pop_trace;
    logic         empty_trace;
    trail_entry_t trace_in;
    trail_entry_t trace_top;
    // Variable state
    logic         write_vs;
    logic         unassign_in_vs;
    config_var    vs_in;
    assign_vec_t  assigned_vec;
    var_idx_t [`LITS_PER_CLAUSE-1:0] rd_var;
    logic [`LITS_PER_CLAUSE-1:0]     rd_assigned;
    logic [`LITS_PER_CLAUSE-1:0]     rd_value;
    // Propagation and decision
    logic         eval;
    logic         reset_bcp;
    logic         conflict;
    logic         bcp_busy;
    clause_idx_t  bcp_clause_idx;
    logic         all_assigned;
    var_idx_t     dec_var;

    sat_control control_i (
        .vs_assigned_head (assigned_vec[imply_head.var_idx]),
        .vs_value_head    (assignment[imply_head.var_idx]),
        .*
    );

    implication_queue imply_q_i (
        .flush (reset_bcp),
        .*
    );

    trail_stack trail_i (.*);

    var_state_table vs_table_i (.*);

    bcp_core bcp_i (.*);

    decider decider_i (.*);

endmodule

// ==== bench/sat_solver_checker.sv ====
`timescale 1ns/1ps
`include "sat_cfg.svh"

module sat_solver_checker (
    input logic clock,
    input logic reset,
    input logic sat,
    input logic unsat,
    input logic push_trace,
    input logic pop_trace,
    input logic push_imply,
    input logic pop_imply,
    input logic reset_bcp
);

    int                      fail_count = 0;
    logic [`MAX_VARS_BITS:0] occupancy;     // Queue fill level tracked from its ports
    logic                    push_taken;
    logic                    pop_taken;

    assign push_taken = push_imply && (occupancy != `MAX_VARS);
    assign pop_taken  = pop_imply && (occupancy != '0);

    always_ff @(posedge clock) begin
        if (reset || reset_bcp)
            occupancy <= '0;    // Flush empties the queue
        else
            occupancy <= occupancy + push_taken - pop_taken;
    end

    result_exclusive: assert property (@(posedge clock) disable iff (reset) !(sat && unsat))
        else begin
            $error("sat and unsat are high together");
            fail_count++;
        end

    trail_one_op: assert property (@(posedge clock) disable iff (reset)
                                   !(push_trace && pop_trace))
        else begin
            $error("trail pushed and popped in the same cycle");
            fail_count++;
        end

    queue_not_full: assert property (@(posedge clock) disable iff (reset)
                                     push_imply |-> (occupancy != `MAX_VARS))
        else begin
            $error("implication queue pushed while full");
            fail_count++;
        end

endmodule

bind sat_solver_top sat_solver_checker checker_i (
    .clock      (clock),
    .reset      (reset),
    .sat        (sat),
    .unsat      (unsat),
    .push_trace (push_trace),
    .pop_trace  (pop_trace),
    .push_imply (push_imply),
    .pop_imply  (pop_imply),
    .reset_bcp  (reset_bcp)
);

// ==== bench/sat_solver_tb.sv ====
`timescale 1ns/1ps
`include "sat_cfg.svh"

module sat_solver_tb
    import sat_types_pkg::*;
();

    localparam int     NUM_RANDOM   = 200;
    localparam int     NUM_FORMULAS = NUM_RANDOM + 2;
    localparam longint CYCLE_LIMIT  = longint'(NUM_FORMULAS) * 256 * 8 * 32;

    logic        clock = 1'b0;
    logic        reset;
    logic        load_clause;
    clause_idx_t load_idx;
    clause_t     load_data;
    clause_cnt_t num_clauses;
    logic        start;
    logic        sat;
    logic        unsat;
    assign_vec_t assignment;

    clause_t     formula [`MAX_CLAUSES];  // Current formula as loaded and as seen by the model
    int          formula_len;
    logic [31:0] lfsr;
    longint      cycle_count = 0;

    sat_solver_top dut_i (.*);

    always #50 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Watchdog and error count of the bound checker
    always @(negedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            abort_run($sformatf("Timeout after %0d cycles without a result", cycle_count));
        if (dut_i.checker_i.fail_count != 0)
            abort_run("An assertion in the bound checker failed");
    end

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            abort_run($sformatf("FAILED at %0t: %s is %b, expected %b",
                                $time, name, actual, expected));
    endtask

    task automatic check_assign(input string name, input assign_vec_t actual,
                                input assign_vec_t expected);
        if (actual !== expected)
            abort_run($sformatf("FAILED at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    function automatic literal_t make_lit(input int var_num, input logic negate);
        literal_t lit;
        lit.var_idx = var_idx_t'(var_num);
        lit.negate  = negate;
        return lit;
    endfunction

    task automatic set_clause(input int idx, input literal_t a, input literal_t b,
                              input literal_t c);
        formula[idx].lit[0] = a;
        formula[idx].lit[1] = b;
        formula[idx].lit[2] = c;
    endtask

    // Every clause needs one literal whose variable differs from its negate bit
    function automatic logic formula_holds(input assign_vec_t a);
        logic clause_ok;
        for (int c = 0; c < formula_len; c++) begin
            clause_ok = 1'b0;
            for (int l = 0; l < `LITS_PER_CLAUSE; l++)
                clause_ok |= (a[formula[c].lit[l].var_idx] != formula[c].lit[l].negate);
            if (!clause_ok)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic logic model_sat();
        for (int a = 0; a < (1 << `MAX_VARS); a++) begin
            if (formula_holds(assign_vec_t'(a)))
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic random_formula();
        logic [31:0] bits;
        logic [31:0] neg;
        take_bits(`MAX_CLAUSES_BITS, bits);
        formula_len = int'(bits) + 1;   // 1 to 32 clauses
        for (int c = 0; c < formula_len; c++) begin
            for (int l = 0; l < `LITS_PER_CLAUSE; l++) begin
                take_bits(`MAX_VARS_BITS, bits);
                take_bits(1, neg);
                formula[c].lit[l] = make_lit(int'(bits), neg[0]);
            end
        end
    endtask

    // Load, start, wait for the result level, compare with the model
    task automatic solve_and_check();
        logic expect_sat;
        expect_sat = model_sat();
        for (int c = 0; c < formula_len; c++) begin
            load_clause = 1'b1;
            load_idx    = clause_idx_t'(c);
            load_data   = formula[c];
            @(negedge clock);
        end
        load_clause = 1'b0;
        num_clauses = clause_cnt_t'(formula_len);
        start       = 1'b1;
        @(negedge clock);
        start = 1'b0;
        check_bit("sat", sat, 1'b0);      // Previous result gone
        check_bit("unsat", unsat, 1'b0);
        while (!sat && !unsat)
            @(negedge clock);
        check_bit("sat", sat, expect_sat);
        check_bit("unsat", unsat, !expect_sat);
        if (sat)
            check_bit("assignment satisfies formula", formula_holds(assignment), 1'b1);
    endtask

    initial begin
        reset       = 1'b1;
        start       = 1'b0;
        load_clause = 1'b0;
        load_idx    = '0;
        load_data   = '0;
        num_clauses = '0;
        lfsr        = 32'he8909fd3;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        check_bit("sat", sat, 1'b0);
        check_bit("unsat", unsat, 1'b0);

        // Chain x0, x0 -> x1, x1 -> x2, the rest decided to 0
        formula_len = 3;
        set_clause(0, make_lit(0, 1'b0), make_lit(0, 1'b0), make_lit(0, 1'b0));
        set_clause(1, make_lit(0, 1'b1), make_lit(1, 1'b0), make_lit(0, 1'b1));
        set_clause(2, make_lit(1, 1'b1), make_lit(2, 1'b0), make_lit(1, 1'b1));
        solve_and_check();
        check_bit("sat", sat, 1'b1);
        check_assign("assignment", assignment, assign_vec_t'(8'b0000_0111));

        // x0 and not x0
        formula_len = 2;
        set_clause(0, make_lit(0, 1'b0), make_lit(0, 1'b0), make_lit(0, 1'b0));
        set_clause(1, make_lit(0, 1'b1), make_lit(0, 1'b1), make_lit(0, 1'b1));
        solve_and_check();
        check_bit("unsat", unsat, 1'b1);

        for (int f = 0; f < NUM_RANDOM; f++) begin
            random_formula();
            solve_and_check();
        end

        if (dut_i.checker_i.fail_count != 0) begin
            abort_run("An assertion in the bound checker failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
+incdir+.
logic/sat_types_pkg.sv
logic/sat_ctrl_pkg.sv
logic/sat_control.sv
logic/trail_stack.sv
logic/implication_queue.sv
logic/var_state_table.sv
logic/bcp_core.sv
logic/decider.sv
logic/sat_solver_top.sv
bench/sat_solver_checker.sv
bench/sat_solver_tb.sv
